/* files.f */
source/l2c_cfg_pkg.sv
source/l2c_req_pkg.sv
source/l2c_ctrl.sv
source/l2c_array.sv
source/l2c_tag_cmp.sv
source/l2c_resp.sv
source/l2c_sub_bank.sv
sim/l2c_sub_bank_chk.sv
sim/l2c_sub_bank_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile the L2 bank testbench with Verilator, run it, then search the log for the result
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module l2c_sub_bank_tb -f files.f

./obj_dir/Vl2c_sub_bank_tb | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
  echo "run.sh: simulation passed"
  exit 0
else
  echo "run.sh: simulation failed"
  exit 1
fi

/* sim/l2c_sub_bank_chk.sv */
// Port protocol checks for the bank, bound into every l2c_sub_bank; disabled during reset
`timescale 1ns/1ns

module l2c_sub_bank_chk (
  input logic forever_cpuclk,
  input logic reset,
  input logic req,
  input logic ack,
  input logic cmplt
);

  int fail_count = 0;

  // ack only rises in answer to req
  ack_rise_needs_req: assert property (@(posedge forever_cpuclk) disable iff (reset)
    (!ack && !req) |=> !ack)
    else begin
      $error("ack rose while req was low");
      fail_count++;
    end

  ack_held_with_req: assert property (@(posedge forever_cpuclk) disable iff (reset)
    (ack && req) |=> ack)
    else begin
      $error("ack fell while req was still high");
      fail_count++;
    end

  // Single-cycle completion pulse
  cmplt_one_cycle: assert property (@(posedge forever_cpuclk) disable iff (reset)
    cmplt |=> !cmplt)
    else begin
      $error("cmplt high on two consecutive cycles");
      fail_count++;
    end

endmodule

bind l2c_sub_bank l2c_sub_bank_chk l2c_sub_bank_chk_inst (
  .forever_cpuclk (forever_cpuclk),
  .reset          (reset         ),
  .req            (req           ),
  .ack            (ack           ),
  .cmplt          (cmplt         )
);

/* sim/l2c_sub_bank_tb.sv */
// One request at a time from the testbench; the model never allocates on reads or invalidates lines
`timescale 1ns/1ns

module l2c_sub_bank_tb;

  localparam int max_cycles = 4000;

  logic                           forever_cpuclk;
  logic                           reset;
  logic                           req;
  logic                           req_write;
  logic [l2c_cfg_pkg::addr_w-1:0] req_addr;
  l2c_req_pkg::sid_t              req_sid;
  l2c_cfg_pkg::line_t             req_wdata;
  logic                           ack;
  logic                           cmplt;
  l2c_req_pkg::sid_t              cmplt_sid;
  l2c_req_pkg::resp_t             cmplt_resp;
  l2c_cfg_pkg::line_t             cmplt_rdata;
  logic                           no_op;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int assert_fails;
  int seed;

  // Model of the bank contents
  l2c_cfg_pkg::tag_t      m_tag   [l2c_cfg_pkg::num_sets][l2c_cfg_pkg::num_ways];
  l2c_cfg_pkg::line_t     m_line  [l2c_cfg_pkg::num_sets][l2c_cfg_pkg::num_ways];
  l2c_cfg_pkg::way_mask_t m_valid [l2c_cfg_pkg::num_sets];
  l2c_cfg_pkg::way_t      m_ptr   [l2c_cfg_pkg::num_sets];

  l2c_sub_bank l2c_sub_bank_inst (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset         ),
    .req            (req           ),
    .req_write      (req_write     ),
    .req_addr       (req_addr      ),
    .req_sid        (req_sid       ),
    .req_wdata      (req_wdata     ),
    .ack            (ack           ),
    .cmplt          (cmplt         ),
    .cmplt_sid      (cmplt_sid     ),
    .cmplt_resp     (cmplt_resp    ),
    .cmplt_rdata    (cmplt_rdata   ),
    .no_op          (no_op         )
  );

  initial forever_cpuclk = 1'b0;
  always #20 forever_cpuclk = ~forever_cpuclk;

  always @(posedge forever_cpuclk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout: test sequence still running after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic expect_resp(input l2c_req_pkg::resp_t got, input l2c_req_pkg::resp_t want);
    check_eq("cmplt_resp", 64'(got), 64'(want));
  endtask

  // Predicts the response and applies the access to the model
  task automatic model_access(input logic write, input logic [15:0] addr,
                              input l2c_cfg_pkg::line_t wdata,
                              output l2c_req_pkg::resp_t exp_resp,
                              output l2c_cfg_pkg::line_t exp_rdata);
    l2c_cfg_pkg::index_t idx;
    l2c_cfg_pkg::tag_t   tag;
    l2c_cfg_pkg::way_t   way;
    logic                hit;
    idx = l2c_cfg_pkg::index_t'(addr);
    tag = addr[l2c_cfg_pkg::addr_w-1:l2c_cfg_pkg::index_w];
    hit = 1'b0;
    way = '0;
    for (int w = 0; w < l2c_cfg_pkg::num_ways; w++) begin
      if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
        hit = 1'b1;
        way = l2c_cfg_pkg::way_t'(w);
      end
    end
    exp_rdata = m_line[idx][way];
    if (!write) begin
      exp_resp = hit ? l2c_req_pkg::resp_rd_hit : l2c_req_pkg::resp_rd_miss;
    end else begin
      if (hit) begin
        exp_resp = l2c_req_pkg::resp_wr_hit;
      end else begin
        way = m_ptr[idx];
        exp_resp = m_valid[idx][way] ? l2c_req_pkg::resp_wr_evict : l2c_req_pkg::resp_wr_fill;
        m_ptr[idx] = way + l2c_cfg_pkg::way_t'(1);
        m_tag[idx][way] = tag;
        m_valid[idx][way] = 1'b1;
      end
      m_line[idx][way] = wdata;
    end
  endtask

  // Four-phase request, then wait for the completion pulse
  task automatic run_txn(input logic write, input logic [15:0] addr,
                         input l2c_req_pkg::sid_t sid, output l2c_req_pkg::resp_t got);
    l2c_req_pkg::resp_t exp_resp;
    l2c_cfg_pkg::line_t exp_rdata;
    l2c_cfg_pkg::line_t wdata;
    int                 ack_cycle;
    wdata = {$random(seed), $random(seed)};
    model_access(write, addr, wdata, exp_resp, exp_rdata);
    // New req only once the previous ack is low
    while (ack) begin
      @(posedge forever_cpuclk);
      #1;
    end
    req_write = write;
    req_addr  = addr;
    req_sid   = sid;
    req_wdata = wdata;
    req       = 1'b1;
    do begin
      @(posedge forever_cpuclk);
      #1;
    end while (!ack);
    ack_cycle = cycles;
    check_eq("no_op", 64'(no_op), 64'd0);
    req = 1'b0;
    do begin
      @(posedge forever_cpuclk);
      #1;
    end while (!cmplt);
    check_eq("cmplt latency", 64'(cycles - ack_cycle), 64'd1);
    check_eq("ack", 64'(ack), 64'd0);
    check_eq("no_op", 64'(no_op), 64'd0);
    check_eq("cmplt_sid", 64'(cmplt_sid), 64'(sid));
    expect_resp(cmplt_resp, exp_resp);
    if (exp_resp == l2c_req_pkg::resp_rd_hit) begin
      check_eq("cmplt_rdata", cmplt_rdata, exp_rdata);
    end
    got = cmplt_resp;
  endtask

  task automatic check_after_reset();
    l2c_req_pkg::resp_t r;
    check_eq("no_op", 64'(no_op), 64'd1);
    check_eq("ack", 64'(ack), 64'd0);
    check_eq("cmplt", 64'(cmplt), 64'd0);
    run_txn(1'b0, 16'h0123, 5'd1, r);
    expect_resp(r, l2c_req_pkg::resp_rd_miss);
    run_txn(1'b0, 16'hfff0, 5'd2, r);
    expect_resp(r, l2c_req_pkg::resp_rd_miss);
  endtask

  task automatic write_then_read();
    l2c_req_pkg::resp_t r;
    run_txn(1'b1, 16'h0122, 5'd3, r);
    expect_resp(r, l2c_req_pkg::resp_wr_fill);
    run_txn(1'b0, 16'h0122, 5'd4, r);
    expect_resp(r, l2c_req_pkg::resp_rd_hit);
    run_txn(1'b1, 16'h0122, 5'd5, r);
    expect_resp(r, l2c_req_pkg::resp_wr_hit);
    run_txn(1'b0, 16'h0122, 5'd6, r);
    expect_resp(r, l2c_req_pkg::resp_rd_hit);
  endtask

  // Five distinct tags in set 7, the first one gets evicted
  task automatic fifo_replacement();
    l2c_req_pkg::resp_t r;
    for (int k = 0; k < 5; k++) begin
      run_txn(1'b1, {12'h100 + 12'(k), 4'h7}, 5'(8 + k), r);
      expect_resp(r, (k < 4) ? l2c_req_pkg::resp_wr_fill : l2c_req_pkg::resp_wr_evict);
    end
    run_txn(1'b0, 16'h1007, 5'd13, r);
    expect_resp(r, l2c_req_pkg::resp_rd_miss);
    for (int k = 1; k < 5; k++) begin
      run_txn(1'b0, {12'h100 + 12'(k), 4'h7}, 5'(13 + k), r);
      expect_resp(r, l2c_req_pkg::resp_rd_hit);
    end
  endtask

  task automatic hazard_stall();
    l2c_req_pkg::resp_t r;
    run_txn(1'b1, 16'h0339, 5'd20, r);
    run_txn(1'b0, 16'h0339, 5'd21, r);
    expect_resp(r, l2c_req_pkg::resp_rd_hit);
    run_txn(1'b1, 16'h044a, 5'd22, r);
    run_txn(1'b1, 16'h055b, 5'd23, r);
    run_txn(1'b0, 16'h044a, 5'd24, r);
    expect_resp(r, l2c_req_pkg::resp_rd_hit);
    run_txn(1'b0, 16'h055b, 5'd25, r);
    expect_resp(r, l2c_req_pkg::resp_rd_hit);
  endtask

  // Back-to-back requests, each accepted while the previous one completes
  task automatic pipelined_sids();
    l2c_req_pkg::resp_t r;
    for (int i = 0; i < 10; i++) begin
      run_txn(i % 2 == 0, {12'h200 + 12'(i / 2), 4'hc}, 5'(26 + i), r);
    end
    @(posedge forever_cpuclk);
    #1;
    check_eq("no_op", 64'(no_op), 64'd1);
  endtask

  initial begin
    seed      = 68427;
    reset     = 1'b1;
    req       = 1'b0;
    req_write = 1'b0;
    req_addr  = '0;
    req_sid   = '0;
    req_wdata = '0;
    for (int s = 0; s < l2c_cfg_pkg::num_sets; s++) begin
      m_valid[s] = '0;
      m_ptr[s]   = '0;
    end
    repeat (3) @(posedge forever_cpuclk);
    #1;
    reset = 1'b0;
    check_after_reset();
    write_then_read();
    fifo_replacement();
    hazard_stall();
    pipelined_sids();
    assert_fails = l2c_sub_bank_inst.l2c_sub_bank_chk_inst.fail_count;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* source/l2c_array.sv */
// One read row and one masked write per edge; a read of the row being written returns the old contents
`timescale 1ns/1ns

module l2c_array #(
  parameter type payload_t = l2c_cfg_pkg::line_t
) (
  input  logic                                     forever_cpuclk,
  input  logic                                     rd_en,
  input  l2c_cfg_pkg::index_t                      rd_index,
  input  l2c_cfg_pkg::index_t                      wr_index,
  input  l2c_cfg_pkg::way_mask_t                   wr_mask,
  input  payload_t                                 wr_data,
  output payload_t [l2c_cfg_pkg::num_ways-1:0]     rd_row
);

  payload_t [l2c_cfg_pkg::num_ways-1:0] mem [l2c_cfg_pkg::num_sets];

  // Whole row out, held until the next read
  always_ff @(posedge forever_cpuclk) begin
    if (rd_en) begin
      rd_row <= mem[rd_index];
    end
  end

  // Per-way write enables within the row
  always_ff @(posedge forever_cpuclk) begin
    for (int w = 0; w < l2c_cfg_pkg::num_ways; w++) begin
      if (wr_mask[w]) begin
        mem[wr_index][w] <= wr_data;
      end
    end
  end

endmodule

/* source/l2c_cfg_pkg.sv */
// Bank geometry is fixed at 16 sets of 4 ways with 64-bit lines; the tag is addr[15:4], the index addr[3:0]
package l2c_cfg_pkg;

  // Line address split
  localparam int addr_w  = 16;
  localparam int index_w = 4;
  localparam int tag_w   = addr_w - index_w;

  // Array shape
  localparam int num_sets = 1 << index_w;
  localparam int num_ways = 4;
  localparam int line_w   = 64;

  typedef logic [$clog2(num_ways)-1:0] way_t;

  // One bit per way, used for write enables and valid bits
  typedef logic [num_ways-1:0] way_mask_t;

  typedef logic [index_w-1:0] index_t;

  typedef logic [tag_w-1:0] tag_t;

  typedef logic [line_w-1:0] line_t;

endpackage

/* source/l2c_ctrl.sv */
// Four-phase req/ack front end; ack stays low while a write to the requested set is in compare
`timescale 1ns/1ns

module l2c_ctrl (
  input  logic                forever_cpuclk,
  input  logic                reset,
  input  logic                req,
  input  logic                req_write,
  input  l2c_cfg_pkg::index_t req_addr,
  input  logic                cmplt,
  output logic                ack,
  output logic                accept,
  output logic                cmp_vld,
  output logic                cmp_write,
  output l2c_cfg_pkg::index_t cmp_index,
  output logic                no_op
);

  logic hazard;

  // Array write and read of one row on the same edge would return stale data
  assign hazard = cmp_vld & cmp_write & (cmp_index == req_addr);

  assign accept = req & ~ack & ~hazard;

  // ack rises on accept, falls on the first edge with req low
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      ack <= 1'b0;
    end else if (accept) begin
      ack <= 1'b1;
    end else if (!req) begin
      ack <= 1'b0;
    end
  end

  // Compare stage lives for exactly one cycle
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      cmp_vld   <= 1'b0;
      cmp_write <= 1'b0;
    end else begin
      cmp_vld <= accept;
      if (accept) begin
        cmp_write <= req_write;
      end
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (accept) begin
      cmp_index <= req_addr;
    end
  end

  // Busy from handshake through completion
  assign no_op = ~(ack | cmp_vld | cmplt);

endmodule

/* source/l2c_req_pkg.sv */
// Response codes cover reads and full-line writes only; there are no partial writes and no write-back
package l2c_req_pkg;

  localparam int sid_w = 5;

  // Requester tag, returned unchanged with the completion
  typedef logic [sid_w-1:0] sid_t;

  // Write miss splits on whether the FIFO victim held a valid line
  typedef enum logic [2:0] {
    resp_rd_hit   = 3'd0,
    resp_rd_miss  = 3'd1,
    resp_wr_hit   = 3'd2,
    resp_wr_fill  = 3'd3,
    resp_wr_evict = 3'd4
  } resp_t;

endpackage

/* source/l2c_resp.sv */
// Completion is a single-cycle pulse with no back-pressure; cmplt_rdata is meaningful only on a read hit
`timescale 1ns/1ns

module l2c_resp (
  input  logic                                       forever_cpuclk,
  input  logic                                       reset,
  input  logic                                       accept,
  input  l2c_req_pkg::sid_t                          req_sid,
  input  l2c_cfg_pkg::line_t                         req_wdata,
  input  logic                                       cmp_vld,
  input  l2c_req_pkg::resp_t                         resp,
  input  l2c_cfg_pkg::way_t                          hit_way,
  input  l2c_cfg_pkg::line_t [l2c_cfg_pkg::num_ways-1:0] line_row,
  output l2c_cfg_pkg::line_t                         cmp_wdata,
  output logic                                       cmplt,
  output l2c_req_pkg::sid_t                          cmplt_sid,
  output l2c_req_pkg::resp_t                         cmplt_resp,
  output l2c_cfg_pkg::line_t                         cmplt_rdata
);

  l2c_req_pkg::sid_t cmp_sid;

  // Request payload held through the compare cycle
  always_ff @(posedge forever_cpuclk) begin
    if (accept) begin
      cmp_sid   <= req_sid;
      cmp_wdata <= req_wdata;
    end
  end

  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      cmplt <= 1'b0;
    end else begin
      cmplt <= cmp_vld;
    end
  end

  // Hit way picks the line read at accept
  always_ff @(posedge forever_cpuclk) begin
    if (cmp_vld) begin
      cmplt_sid   <= cmp_sid;
      cmplt_resp  <= resp;
      cmplt_rdata <= line_row[hit_way];
    end
  end

endmodule

/* source/l2c_sub_bank.sv */
// One L2 bank, 16 sets x 4 ways; one request accepted per handshake, cmplt one cycle after ack rises
`timescale 1ns/1ns

module l2c_sub_bank (
  input  logic                          forever_cpuclk,
  input  logic                          reset,
  input  logic                          req,
  input  logic                          req_write,
  input  logic [l2c_cfg_pkg::addr_w-1:0] req_addr,
  input  l2c_req_pkg::sid_t             req_sid,
  input  l2c_cfg_pkg::line_t            req_wdata,
  output logic                          ack,
  output logic                          cmplt,
  output l2c_req_pkg::sid_t             cmplt_sid,
  output l2c_req_pkg::resp_t            cmplt_resp,
  output l2c_cfg_pkg::line_t            cmplt_rdata,
  output logic                          no_op
);

  logic                                          accept;
  logic                                          cmp_vld;
  logic                                          cmp_write;
  l2c_cfg_pkg::index_t                           cmp_index;
  l2c_cfg_pkg::way_mask_t                        wr_mask;
  l2c_cfg_pkg::tag_t                             wr_tag;
  l2c_cfg_pkg::way_t                             hit_way;
  l2c_req_pkg::resp_t                            resp;
  l2c_cfg_pkg::line_t                            cmp_wdata;
  l2c_cfg_pkg::tag_t [l2c_cfg_pkg::num_ways-1:0]  tag_row;
  l2c_cfg_pkg::line_t [l2c_cfg_pkg::num_ways-1:0] line_row;

  l2c_ctrl x_l2c_ctrl (
    .forever_cpuclk (forever_cpuclk                       ),
    .reset          (reset                                ),
    .req            (req                                  ),
    .req_write      (req_write                            ),
    .req_addr       (req_addr[l2c_cfg_pkg::index_w-1:0]   ),
    .cmplt          (cmplt                                ),
    .ack            (ack                                  ),
    .accept         (accept                               ),
    .cmp_vld        (cmp_vld                              ),
    .cmp_write      (cmp_write                            ),
    .cmp_index      (cmp_index                            ),
    .no_op          (no_op                                )
  );

  l2c_array #(.payload_t(l2c_cfg_pkg::tag_t)) x_l2c_tag_array (
    .forever_cpuclk (forever_cpuclk                       ),
    .rd_en          (accept                               ),
    .rd_index       (req_addr[l2c_cfg_pkg::index_w-1:0]   ),
    .wr_index       (cmp_index                            ),
    .wr_mask        (wr_mask                              ),
    .wr_data        (wr_tag                               ),
    .rd_row         (tag_row                              )
  );

  l2c_array #(.payload_t(l2c_cfg_pkg::line_t)) x_l2c_line_array (
    .forever_cpuclk (forever_cpuclk                       ),
    .rd_en          (accept                               ),
    .rd_index       (req_addr[l2c_cfg_pkg::index_w-1:0]   ),
    .wr_index       (cmp_index                            ),
    .wr_mask        (wr_mask                              ),
    .wr_data        (cmp_wdata                            ),
    .rd_row         (line_row                             )
  );

  l2c_tag_cmp x_l2c_tag_cmp (
    .forever_cpuclk (forever_cpuclk                                         ),
    .reset          (reset                                                  ),
    .accept         (accept                                                 ),
    .req_addr       (req_addr[l2c_cfg_pkg::addr_w-1:l2c_cfg_pkg::index_w]   ),
    .cmp_vld        (cmp_vld                                                ),
    .cmp_write      (cmp_write                                              ),
    .cmp_index      (cmp_index                                              ),
    .tag_row        (tag_row                                                ),
    .wr_mask        (wr_mask                                                ),
    .wr_tag         (wr_tag                                                 ),
    .hit_way        (hit_way                                                ),
    .resp           (resp                                                   )
  );

  l2c_resp x_l2c_resp (
    .forever_cpuclk (forever_cpuclk),
    .reset          (reset         ),
    .accept         (accept        ),
    .req_sid        (req_sid       ),
    .req_wdata      (req_wdata     ),
    .cmp_vld        (cmp_vld       ),
    .resp           (resp          ),
    .hit_way        (hit_way       ),
    .line_row       (line_row      ),
    .cmp_wdata      (cmp_wdata     ),
    .cmplt          (cmplt         ),
    .cmplt_sid      (cmplt_sid     ),
    .cmplt_resp     (cmplt_resp    ),
    .cmplt_rdata    (cmplt_rdata   )
  );

endmodule

/* source/l2c_tag_cmp.sv */
// Write misses allocate in strict per-set FIFO order; reads never allocate and lines are never invalidated
`timescale 1ns/1ns

module l2c_tag_cmp (
  input  logic                                      forever_cpuclk,
  input  logic                                      reset,
  input  logic                                      accept,
  input  l2c_cfg_pkg::tag_t                         req_addr,
  input  logic                                      cmp_vld,
  input  logic                                      cmp_write,
  input  l2c_cfg_pkg::index_t                       cmp_index,
  input  l2c_cfg_pkg::tag_t [l2c_cfg_pkg::num_ways-1:0] tag_row,
  output l2c_cfg_pkg::way_mask_t                    wr_mask,
  output l2c_cfg_pkg::tag_t                         wr_tag,
  output l2c_cfg_pkg::way_t                         hit_way,
  output l2c_req_pkg::resp_t                        resp
);

  l2c_cfg_pkg::tag_t      cmp_tag;
  l2c_cfg_pkg::way_mask_t valid [l2c_cfg_pkg::num_sets];
  l2c_cfg_pkg::way_t      fifo_ptr [l2c_cfg_pkg::num_sets];
  l2c_cfg_pkg::way_mask_t row_valid;
  l2c_cfg_pkg::way_mask_t hit_vec;
  l2c_cfg_pkg::way_t      victim;
  l2c_cfg_pkg::way_t      wr_way;
  logic                   hit;
  logic                   wr_en;

  always_ff @(posedge forever_cpuclk) begin
    if (accept) begin
      cmp_tag <= req_addr;
    end
  end

  assign row_valid = valid[cmp_index];
  assign victim    = fifo_ptr[cmp_index];

  // Tags within a set are unique, so at most one way hits
  always_comb begin
    hit_vec = '0;
    hit_way = '0;
    for (int w = 0; w < l2c_cfg_pkg::num_ways; w++) begin
      hit_vec[w] = row_valid[w] & (tag_row[w] == cmp_tag);
      if (hit_vec[w]) begin
        hit_way = l2c_cfg_pkg::way_t'(w);
      end
    end
  end

  assign hit    = |hit_vec;
  assign wr_en  = cmp_vld & cmp_write;
  assign wr_way = hit ? hit_way : victim;
  assign wr_tag = cmp_tag;

  // Same mask goes to tag and line arrays
  always_comb begin
    wr_mask = '0;
    if (wr_en) begin
      wr_mask[wr_way] = 1'b1;
    end
  end

  always_comb begin
    if (!cmp_write) begin
      resp = hit ? l2c_req_pkg::resp_rd_hit : l2c_req_pkg::resp_rd_miss;
    end else if (hit) begin
      resp = l2c_req_pkg::resp_wr_hit;
    end else if (row_valid[victim]) begin
      resp = l2c_req_pkg::resp_wr_evict;
    end else begin
      resp = l2c_req_pkg::resp_wr_fill;
    end
  end

  // Pointer moves only when a new line is allocated
  always_ff @(posedge forever_cpuclk) begin
    if (reset) begin
      for (int s = 0; s < l2c_cfg_pkg::num_sets; s++) begin
        valid[s]    <= '0;
        fifo_ptr[s] <= '0;
      end
    end else if (wr_en) begin
      valid[cmp_index][wr_way] <= 1'b1;
      if (!hit) begin
        fifo_ptr[cmp_index] <= victim + l2c_cfg_pkg::way_t'(1);
      end
    end
  end

endmodule
